// File: verilog/router_regs_pkg.sv
////////////////////////////////////////////////////////////////////////////
// Ingress router CSR package
// Register map, counter indices, response codes and bus widths
////////////////////////////////////////////////////////////////////////////

`default_nettype none

package router_regs_pkg;

    // Avalon-MM bus widths
    localparam int DATALEN      = 32;
    localparam int ADDRLEN      = 15;
    localparam int WORD_ADDRLEN = ADDRLEN - 2;

    // Word addresses of the register map
    typedef enum logic [WORD_ADDRLEN-1:0] {
        ADDR_VERSION_ID,
        ADDR_PARAMS0,
        ADDR_ING_PORT_ENABLE_CON,
        ADDR_ING_PORT_ENABLE_STAT,
        ADDR_ING_CNTRS_SAMPLE_CON,
        ADDR_ING_CNTRS_READ_SEL,
        ADDR_ING_CNTRS_READ_DATA,
        TOTAL_REGS
    } reg_addr_e;

    // Counter order within one port
    typedef enum logic [7:0] {
        CNTR_PKT,
        CNTR_BYTE,
        CNTR_ERR,
        CNTR_ASYNC_FIFO_OVF,
        CNTR_BUF_OVF
    } cntr_idx_e;

    localparam int NUM_CNTRS_PER_PORT = int'(CNTR_BUF_OVF) + 1;

    typedef enum logic [1:0] {
        RESP_OKAY        = 2'd0,
        RESP_SLAVE_ERROR = 2'd2
    } avmm_resp_e;

    // Major 1, minor 0
    localparam logic [15:0] MODULE_VERSION = {8'd1, 8'd0};

    // Read-select layout, port in 15:8 and counter in 7:0
    localparam int READ_SEL_W        = 16;
    localparam int READ_SEL_FIELD_W  = 8;
    localparam int READ_SEL_PORT_LSB = 8;
    localparam int READ_SEL_CNTR_LSB = 0;

endpackage

`default_nettype wire

// File: verilog/avmm_reg_decode.sv
////////////////////////////////////////////////////////////////////////////
// Avalon-MM slave for the ingress CSRs
// Decodes word addresses, holds control registers and builds responses
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/1ns
`default_nettype none

module avmm_reg_decode
    import router_regs_pkg::*;
#(
    parameter int          NUM_ING_PHYS_PORTS = 11,
    parameter logic [15:0] MODULE_ID          = 16'd10,
    parameter int          MTU_BYTES          = 2000,
    parameter int          COUNTERS_WIDTH     = 32
) (
    input  wire                           avmm_clk_ifc,
    input  wire                           peripheral_sresetn_core,
    input  wire  [ADDRLEN-1:0]            address,
    input  wire                           read,
    input  wire                           write,
    input  wire  [DATALEN-1:0]            writedata,
    input  wire  [DATALEN/8-1:0]          byteenable,
    output logic [DATALEN-1:0]            readdata,
    output logic                          readdatavalid,
    output avmm_resp_e                    response,
    output logic                          writeresponsevalid,
    output logic [NUM_ING_PHYS_PORTS-1:0] ing_phys_ports_enable,
    output logic [NUM_ING_PHYS_PORTS-1:0] sample_pulse,
    output logic [READ_SEL_W-1:0]         read_sel,
    input  wire  [DATALEN-1:0]            read_data
);

    localparam logic [DATALEN-1:0] VERSION_ID_VAL = {MODULE_VERSION, MODULE_ID};
    localparam logic [DATALEN-1:0] PARAMS0_VAL    = {
        16'(MTU_BYTES), 8'(COUNTERS_WIDTH), 8'(NUM_ING_PHYS_PORTS)
    };

    logic [WORD_ADDRLEN-1:0]       word_index;
    reg_addr_e                     word_addr;
    logic                          addr_err;
    logic [DATALEN-1:0]            reg_rdata;
    logic [DATALEN-1:0]            wr_merged;
    logic [NUM_ING_PHYS_PORTS-1:0] port_enable_con;
    logic [NUM_ING_PHYS_PORTS-1:0] port_enable_stat;
    logic [NUM_ING_PHYS_PORTS-1:0] sample_con;
    logic [NUM_ING_PHYS_PORTS-1:0] sample_con_d;

    // Replace only the enabled byte lanes of the current value
    function automatic logic [DATALEN-1:0] lane_merge(
        input logic [DATALEN-1:0]   cur,
        input logic [DATALEN-1:0]   wdata,
        input logic [DATALEN/8-1:0] be
    );
        logic [DATALEN-1:0] merged;
        merged = cur;
        for (int i = 0; i < DATALEN/8; i++) begin
            if (be[i]) begin
                merged[i*8 +: 8] = wdata[i*8 +: 8];
            end
        end
        return merged;
    endfunction

    ////////////////////////////////////////////////////////////////////////////
    // Address decode and read mux
    ////////////////////////////////////////////////////////////////////////////

    assign word_index = address[ADDRLEN-1:2];
    assign word_addr  = reg_addr_e'(word_index);
    assign addr_err   = (word_index >= TOTAL_REGS);

    always_comb begin
        case (word_addr)
            ADDR_VERSION_ID:           reg_rdata = VERSION_ID_VAL;
            ADDR_PARAMS0:              reg_rdata = PARAMS0_VAL;
            ADDR_ING_PORT_ENABLE_CON:  reg_rdata = DATALEN'(port_enable_con);
            ADDR_ING_PORT_ENABLE_STAT: reg_rdata = DATALEN'(port_enable_stat);
            ADDR_ING_CNTRS_SAMPLE_CON: reg_rdata = DATALEN'(sample_con);
            ADDR_ING_CNTRS_READ_SEL:   reg_rdata = DATALEN'(read_sel);
            ADDR_ING_CNTRS_READ_DATA:  reg_rdata = read_data;
            default:                   reg_rdata = '0;
        endcase
    end

    // The addressed register's readback is its current stored value
    assign wr_merged = lane_merge(reg_rdata, writedata, byteenable);

    ////////////////////////////////////////////////////////////////////////////
    // Control registers
    ////////////////////////////////////////////////////////////////////////////

    always_ff @(posedge avmm_clk_ifc) begin
        if (!peripheral_sresetn_core) begin
            port_enable_con <= '1;
            sample_con      <= '0;
            read_sel        <= '0;
        end else if (write && !addr_err) begin
            case (word_addr)
                ADDR_ING_PORT_ENABLE_CON:  port_enable_con <= wr_merged[NUM_ING_PHYS_PORTS-1:0];
                ADDR_ING_CNTRS_SAMPLE_CON: sample_con      <= wr_merged[NUM_ING_PHYS_PORTS-1:0];
                ADDR_ING_CNTRS_READ_SEL:   read_sel        <= wr_merged[READ_SEL_W-1:0];
                default: begin
                end
            endcase
        end
    end

    // Status copy and 0-to-1 detect on the sample bits
    always_ff @(posedge avmm_clk_ifc) begin
        if (!peripheral_sresetn_core) begin
            port_enable_stat <= '1;
            sample_con_d     <= '0;
            sample_pulse     <= '0;
        end else begin
            port_enable_stat <= port_enable_con;
            sample_con_d     <= sample_con;
            sample_pulse     <= sample_con & ~sample_con_d;
        end
    end

    assign ing_phys_ports_enable = port_enable_con;

    ////////////////////////////////////////////////////////////////////////////
    // Response path
    ////////////////////////////////////////////////////////////////////////////

    always_ff @(posedge avmm_clk_ifc) begin
        if (!peripheral_sresetn_core) begin
            readdatavalid      <= 1'b0;
            writeresponsevalid <= 1'b0;
            response           <= RESP_OKAY;
        end else begin
            readdatavalid      <= read;
            writeresponsevalid <= write;
            if (read || write) begin
                response <= addr_err ? RESP_SLAVE_ERROR : RESP_OKAY;
            end
        end
    end

    // Out-of-map addresses fall to the zero default of the read mux
    always_ff @(posedge avmm_clk_ifc) begin
        if (read) begin
            readdata <= reg_rdata;
        end
    end

    a_no_rd_wr_overlap: assert property (
        @(posedge avmm_clk_ifc) disable iff (!peripheral_sresetn_core)
        !(read && write)
    );

    a_no_resp_overlap: assert property (
        @(posedge avmm_clk_ifc) disable iff (!peripheral_sresetn_core)
        !(readdatavalid && writeresponsevalid)
    );

endmodule

`default_nettype wire

// File: verilog/ing_port_counters.sv
////////////////////////////////////////////////////////////////////////////
// Counter slice for one ingress port
// Counts overflow edges and holds the sampled counter bank
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/1ns
`default_nettype none

module ing_port_counters
    import router_regs_pkg::*;
#(
    parameter int COUNTERS_WIDTH = 32
) (
    input  wire                                      avmm_clk_ifc,
    input  wire                                      peripheral_sresetn_core,
    input  wire                                      sample_pulse,
    input  wire  [COUNTERS_WIDTH-1:0]                pkt_cnt,
    input  wire  [COUNTERS_WIDTH-1:0]                byte_cnt,
    input  wire  [COUNTERS_WIDTH-1:0]                err_cnt,
    input  wire                                      async_fifo_overflow,
    input  wire                                      buf_overflow,
    output logic [NUM_CNTRS_PER_PORT*COUNTERS_WIDTH-1:0] sampled_cnts
);

    logic                                           async_fifo_overflow_d;
    logic                                           buf_overflow_d;
    logic [COUNTERS_WIDTH-1:0]                      async_fifo_ovf_cnt;
    logic [COUNTERS_WIDTH-1:0]                      buf_ovf_cnt;
    logic [NUM_CNTRS_PER_PORT-1:0][COUNTERS_WIDTH-1:0] sampled;

    ////////////////////////////////////////////////////////////////////////////
    // Overflow edge counters
    ////////////////////////////////////////////////////////////////////////////

    always_ff @(posedge avmm_clk_ifc) begin
        if (!peripheral_sresetn_core) begin
            async_fifo_overflow_d <= 1'b0;
            buf_overflow_d        <= 1'b0;
            async_fifo_ovf_cnt    <= '0;
            buf_ovf_cnt           <= '0;
        end else begin
            async_fifo_overflow_d <= async_fifo_overflow;
            buf_overflow_d        <= buf_overflow;

            // A sample clears the count and drops a coinciding edge
            if (sample_pulse) begin
                async_fifo_ovf_cnt <= '0;
            end else if (async_fifo_overflow && !async_fifo_overflow_d) begin
                async_fifo_ovf_cnt <= async_fifo_ovf_cnt + 1'b1;
            end

            if (sample_pulse) begin
                buf_ovf_cnt <= '0;
            end else if (buf_overflow && !buf_overflow_d) begin
                buf_ovf_cnt <= buf_ovf_cnt + 1'b1;
            end
        end
    end

    // Sampled bank
    always_ff @(posedge avmm_clk_ifc) begin
        if (!peripheral_sresetn_core) begin
            sampled <= '0;
        end else if (sample_pulse) begin
            sampled[CNTR_PKT]            <= pkt_cnt;
            sampled[CNTR_BYTE]           <= byte_cnt;
            sampled[CNTR_ERR]            <= err_cnt;
            sampled[CNTR_ASYNC_FIFO_OVF] <= async_fifo_ovf_cnt;
            sampled[CNTR_BUF_OVF]        <= buf_ovf_cnt;
        end
    end

    assign sampled_cnts = sampled;

    a_pulse_single_cycle: assert property (
        @(posedge avmm_clk_ifc) disable iff (!peripheral_sresetn_core)
        sample_pulse |=> !sample_pulse
    );

endmodule

`default_nettype wire

// File: verilog/ing_cntr_read_mux.sv
////////////////////////////////////////////////////////////////////////////
// Sampled counter read window
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/1ns
`default_nettype none

module ing_cntr_read_mux
    import router_regs_pkg::*;
#(
    parameter int NUM_ING_PHYS_PORTS = 11,
    parameter int COUNTERS_WIDTH     = 32
) (
    input  wire                    avmm_clk_ifc,
    input  wire                    peripheral_sresetn_core,
    input  wire [READ_SEL_W-1:0]   read_sel,
    input  wire [NUM_ING_PHYS_PORTS*NUM_CNTRS_PER_PORT*COUNTERS_WIDTH-1:0] sampled_cnts,
    output logic [DATALEN-1:0]     read_data
);

    logic [READ_SEL_FIELD_W-1:0] port_field;
    logic [READ_SEL_FIELD_W-1:0] cntr_field;
    logic                        port_in_range;
    logic                        sel_in_range;
    int                          sel_idx;

    assign port_field    = read_sel[READ_SEL_PORT_LSB +: READ_SEL_FIELD_W];
    assign cntr_field    = read_sel[READ_SEL_CNTR_LSB +: READ_SEL_FIELD_W];
    assign port_in_range = (port_field < NUM_ING_PHYS_PORTS);
    assign sel_in_range  = port_in_range && (cntr_field < NUM_CNTRS_PER_PORT);

    // Flat position of the counter in the per-port banks
    assign sel_idx = sel_in_range ? int'(port_field) * NUM_CNTRS_PER_PORT + int'(cntr_field) : 0;

    always_ff @(posedge avmm_clk_ifc) begin
        if (!peripheral_sresetn_core) begin
            read_data <= '0;
        end else if (sel_in_range) begin
            read_data <= DATALEN'(sampled_cnts[sel_idx*COUNTERS_WIDTH +: COUNTERS_WIDTH]);
        end else begin
            read_data <= '0;
        end
    end

    a_oob_port_reads_zero: assert property (
        @(posedge avmm_clk_ifc) disable iff (!peripheral_sresetn_core)
        !port_in_range |=> (read_data == '0)
    );

endmodule

`default_nettype wire

// File: verilog/router_avmm_regs.sv
////////////////////////////////////////////////////////////////////////////
// Ingress router CSR block top level
// Connects the register decoder, per-port counter slices and read window
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/1ns
`default_nettype none

module router_avmm_regs
    import router_regs_pkg::*;
#(
    parameter int          NUM_ING_PHYS_PORTS = 11,
    parameter int          COUNTERS_WIDTH     = 32,
    parameter logic [15:0] MODULE_ID          = 16'd10,
    parameter int          MTU_BYTES          = 2000
) (
    input  wire                                         avmm_clk_ifc,
    input  wire                                         peripheral_sresetn_core,

    // Avalon-MM slave
    input  wire  [ADDRLEN-1:0]                          address,
    input  wire                                         read,
    input  wire                                         write,
    input  wire  [DATALEN-1:0]                          writedata,
    input  wire  [DATALEN/8-1:0]                        byteenable,
    output logic [DATALEN-1:0]                          readdata,
    output logic                                        readdatavalid,
    output avmm_resp_e                                  response,
    output logic                                        writeresponsevalid,

    // Ingress port logic
    output logic [NUM_ING_PHYS_PORTS-1:0]               ing_phys_ports_enable,
    input  wire  [NUM_ING_PHYS_PORTS*COUNTERS_WIDTH-1:0] ing_pkt_cnts,
    input  wire  [NUM_ING_PHYS_PORTS*COUNTERS_WIDTH-1:0] ing_byte_cnts,
    input  wire  [NUM_ING_PHYS_PORTS*COUNTERS_WIDTH-1:0] ing_err_cnts,
    input  wire  [NUM_ING_PHYS_PORTS-1:0]               ing_async_fifo_overflow,
    input  wire  [NUM_ING_PHYS_PORTS-1:0]               ing_buf_overflow
);

    localparam int BANK_W = NUM_CNTRS_PER_PORT * COUNTERS_WIDTH;

    logic [NUM_ING_PHYS_PORTS-1:0]        sample_pulse;
    logic [NUM_ING_PHYS_PORTS*BANK_W-1:0] sampled_cnts;
    logic [READ_SEL_W-1:0]                read_sel;
    logic [DATALEN-1:0]                   read_data;

    avmm_reg_decode #(
        .NUM_ING_PHYS_PORTS ( NUM_ING_PHYS_PORTS ),
        .MODULE_ID          ( MODULE_ID          ),
        .MTU_BYTES          ( MTU_BYTES          ),
        .COUNTERS_WIDTH     ( COUNTERS_WIDTH     )
    ) avmm_reg_decode_i (
        .avmm_clk_ifc            ( avmm_clk_ifc            ),
        .peripheral_sresetn_core ( peripheral_sresetn_core ),
        .address                 ( address                 ),
        .read                    ( read                    ),
        .write                   ( write                   ),
        .writedata               ( writedata               ),
        .byteenable              ( byteenable              ),
        .readdata                ( readdata                ),
        .readdatavalid           ( readdatavalid           ),
        .response                ( response                ),
        .writeresponsevalid      ( writeresponsevalid      ),
        .ing_phys_ports_enable   ( ing_phys_ports_enable   ),
        .sample_pulse            ( sample_pulse            ),
        .read_sel                ( read_sel                ),
        .read_data               ( read_data               )
    );

    // One counter slice per ingress port
    for (genvar p = 0; p < NUM_ING_PHYS_PORTS; p++) begin : gen_port
        ing_port_counters #(
            .COUNTERS_WIDTH ( COUNTERS_WIDTH )
        ) ing_port_counters_i (
            .avmm_clk_ifc            ( avmm_clk_ifc                                     ),
            .peripheral_sresetn_core ( peripheral_sresetn_core                          ),
            .sample_pulse            ( sample_pulse[p]                                  ),
            .pkt_cnt                 ( ing_pkt_cnts[p*COUNTERS_WIDTH +: COUNTERS_WIDTH]  ),
            .byte_cnt                ( ing_byte_cnts[p*COUNTERS_WIDTH +: COUNTERS_WIDTH] ),
            .err_cnt                 ( ing_err_cnts[p*COUNTERS_WIDTH +: COUNTERS_WIDTH]  ),
            .async_fifo_overflow     ( ing_async_fifo_overflow[p]                       ),
            .buf_overflow            ( ing_buf_overflow[p]                              ),
            .sampled_cnts            ( sampled_cnts[p*BANK_W +: BANK_W]                 )
        );
    end

    ing_cntr_read_mux #(
        .NUM_ING_PHYS_PORTS ( NUM_ING_PHYS_PORTS ),
        .COUNTERS_WIDTH     ( COUNTERS_WIDTH     )
    ) ing_cntr_read_mux_i (
        .avmm_clk_ifc            ( avmm_clk_ifc            ),
        .peripheral_sresetn_core ( peripheral_sresetn_core ),
        .read_sel                ( read_sel                ),
        .sampled_cnts            ( sampled_cnts            ),
        .read_data               ( read_data               )
    );

endmodule

`default_nettype wire

// File: testbench/router_avmm_regs_tb.sv
////////////////////////////////////////////////////////////////////////////
// Testbench for the ingress router CSR block
// Runs the register pattern file, then random sampling against a model
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/1ns
`default_nettype none

module router_avmm_regs_tb
    import router_regs_pkg::*;
();

    localparam int NUM_PORTS    = 11;
    localparam int CW           = 32;
    localparam int MAX_LINES    = 128;
    localparam int RAND_ROUNDS  = 4;
    localparam int RESET_CYCLES = 8;

    // Pattern opcodes
    localparam logic [7:0] OP_END_TEST  = 8'h00;
    localparam logic [7:0] OP_WRITE     = 8'h01;
    localparam logic [7:0] OP_READ      = 8'h02;
    localparam logic [7:0] OP_SET_COUNT = 8'h03;
    localparam logic [7:0] OP_PULSE_OVF = 8'h04;
    localparam logic [7:0] OP_SAMPLE    = 8'h05;
    localparam logic [7:0] OP_WAIT      = 8'h06;
    localparam logic [7:0] OP_READ_CNTR = 8'h07;
    localparam logic [7:0] OP_NONE      = 8'hFF;

    logic                    avmm_clk_ifc;
    logic                    peripheral_sresetn_core;
    logic [ADDRLEN-1:0]      address;
    logic                    read;
    logic                    write;
    logic [DATALEN-1:0]      writedata;
    logic [DATALEN/8-1:0]    byteenable;
    logic [DATALEN-1:0]      readdata;
    logic                    readdatavalid;
    logic [1:0]              response;
    logic                    writeresponsevalid;
    logic [NUM_PORTS-1:0]    ing_phys_ports_enable;
    logic [NUM_PORTS*CW-1:0] ing_pkt_cnts;
    logic [NUM_PORTS*CW-1:0] ing_byte_cnts;
    logic [NUM_PORTS*CW-1:0] ing_err_cnts;
    logic [NUM_PORTS-1:0]    ing_async_fifo_overflow;
    logic [NUM_PORTS-1:0]    ing_buf_overflow;

    logic [95:0] patterns [0:MAX_LINES-1];
    logic [31:0] model [NUM_PORTS][NUM_CNTRS_PER_PORT];
    integer      seed;
    int          num_lines;
    int          cycle_limit   = 0;
    int          cycle_count   = 0;
    int          error_count   = 0;
    int          check_count   = 0;
    int          errors_before = 0;

    router_avmm_regs router_avmm_regs_i (.*);

    initial begin
        avmm_clk_ifc = 1'b0;
        forever #4 avmm_clk_ifc = ~avmm_clk_ifc;
    end

    task automatic check_value(input string name, input logic [31:0] exp,
                               input logic [31:0] act);
        check_count++;
        assert (act === exp) else begin
            $display("FAILED at %0t ns: %s expected %h, got %h", $time, name, exp, act);
            error_count++;
        end
    endtask

    task automatic check_valid(input logic valid, input string what);
        check_count++;
        assert (valid) else begin
            $display("Error at %0t ns: %s did not arrive one cycle after its strobe",
                     $time, what);
            error_count++;
        end
    endtask

    ////////////////////////////////////////////////////////////////////////////
    // Bus access, entered and left on a falling edge
    ////////////////////////////////////////////////////////////////////////////

    task automatic bus_write(input logic [ADDRLEN-1:0] addr, input logic [31:0] data,
                             input logic [3:0] be, input logic [1:0] exp_resp);
        address    = addr;
        writedata  = data;
        byteenable = be;
        write      = 1'b1;
        @(negedge avmm_clk_ifc);
        write = 1'b0;
        check_valid(writeresponsevalid, "writeresponsevalid");
        check_value($sformatf("response@%h", addr), 32'(exp_resp), 32'(response));
    endtask

    task automatic bus_read(input logic [ADDRLEN-1:0] addr, input logic [31:0] exp_data,
                            input logic [1:0] exp_resp, input string label);
        address = addr;
        read    = 1'b1;
        @(negedge avmm_clk_ifc);
        read = 1'b0;
        check_valid(readdatavalid, "readdatavalid");
        check_value($sformatf("response@%h", addr), 32'(exp_resp), 32'(response));
        check_value(label, exp_data, readdata);
    endtask

    task automatic read_counter(input logic [7:0] port, input logic [7:0] cntr,
                                input logic [31:0] exp);
        bus_write({ADDR_ING_CNTRS_READ_SEL, 2'b00}, {16'd0, port, cntr}, 4'hF, RESP_OKAY);
        // Window register follows read_sel one cycle later
        @(negedge avmm_clk_ifc);
        bus_read({ADDR_ING_CNTRS_READ_DATA, 2'b00}, exp, RESP_OKAY,
                 $sformatf("counter p%0d c%0d", port, cntr));
    endtask

    task automatic set_count(input int port, input int cntr, input logic [31:0] value);
        case (cntr)
            0:       ing_pkt_cnts[port*CW +: CW]  = value;
            1:       ing_byte_cnts[port*CW +: CW] = value;
            default: ing_err_cnts[port*CW +: CW]  = value;
        endcase
    endtask

    // Port FFFF means every port p gets count + p edges
    task automatic pulse_overflows(input logic [15:0] port, input int count);
        int edges [NUM_PORTS];
        int longest;
        longest = 0;
        for (int p = 0; p < NUM_PORTS; p++) begin
            edges[p] = (port == 16'hFFFF) ? count + p : ((int'(port) == p) ? count : 0);
            if (edges[p] > longest) longest = edges[p];
        end
        for (int k = 0; k < longest; k++) begin
            for (int p = 0; p < NUM_PORTS; p++) begin
                if (k < edges[p]) begin
                    ing_async_fifo_overflow[p] = 1'b1;
                    ing_buf_overflow[p]        = 1'b1;
                end
            end
            @(negedge avmm_clk_ifc);
            ing_async_fifo_overflow = '0;
            ing_buf_overflow        = '0;
            @(negedge avmm_clk_ifc);
        end
    endtask

    task automatic sample_ports(input logic [31:0] mask);
        bus_write({ADDR_ING_CNTRS_SAMPLE_CON, 2'b00}, mask, 4'hF, RESP_OKAY);
        // Pulse, capture, then the bank is readable
        repeat (4) @(negedge avmm_clk_ifc);
    endtask

    task automatic scan_counters();
        for (int p = 0; p < NUM_PORTS; p++) begin
            for (int c = 0; c < NUM_CNTRS_PER_PORT; c++) begin
                read_counter(8'(p), 8'(c), model[p][c]);
            end
        end
    endtask

    function automatic string test_name(input int num);
        case (num)
            1:       return "reset_values";
            2:       return "byte_enable_writes";
            3:       return "error_response";
            4:       return "input_count_sampling";
            5:       return "overflow_counting";
            default: return "random_sampling";
        endcase
    endfunction

    task automatic report_test(input int num);
        $display("Test %0d %s: %0d errors", num, test_name(num), error_count - errors_before);
        errors_before = error_count;
    endtask

    ////////////////////////////////////////////////////////////////////////////
    // Pattern driver and random section
    ////////////////////////////////////////////////////////////////////////////

    task automatic run_patterns();
        logic [7:0]  op;
        logic [15:0] addr;
        logic [31:0] data;
        logic [7:0]  be;
        logic [31:0] exp;
        for (int i = 0; i < num_lines; i++) begin
            {op, addr, data, be, exp} = patterns[i];
            case (op)
                OP_END_TEST: begin
                    // Every sampled counter is still zero at the end of the reset test
                    if (data == 32'd1) begin
                        scan_counters();
                    end
                    report_test(int'(data));
                end
                OP_WRITE:     bus_write(addr[ADDRLEN-1:0], data, be[3:0], exp[1:0]);
                OP_READ: begin
                    bus_read(addr[ADDRLEN-1:0], exp, be[1:0], $sformatf("readdata@%h", addr));
                    if (addr[ADDRLEN-1:2] == ADDR_ING_PORT_ENABLE_CON) begin
                        check_value("ing_phys_ports_enable", exp, 32'(ing_phys_ports_enable));
                    end
                end
                OP_SET_COUNT: set_count(int'(addr), int'(be), data);
                OP_PULSE_OVF: pulse_overflows(addr, int'(data));
                OP_SAMPLE:    sample_ports(data);
                OP_WAIT:      repeat (data) @(negedge avmm_clk_ifc);
                OP_READ_CNTR: read_counter(addr[7:0], be, exp);
                default: begin
                    $display("Error: unknown opcode %h on pattern line %0d", op, i);
                    error_count++;
                end
            endcase
        end
    endtask

    task automatic random_sampling();
        logic [NUM_PORTS-1:0] mask;
        logic [31:0]          value;
        for (int r = 0; r < RAND_ROUNDS; r++) begin
            // First round samples every port so the model starts from known values
            mask = (r == 0) ? '1 : NUM_PORTS'($random(seed));
            for (int p = 0; p < NUM_PORTS; p++) begin
                for (int c = 0; c <= int'(CNTR_ERR); c++) begin
                    value = $random(seed);
                    set_count(p, c, value);
                    if (mask[p]) model[p][c] = value;
                end
                // No overflow edges here, and sampling clears the running counts
                if (mask[p]) begin
                    model[p][CNTR_ASYNC_FIFO_OVF] = '0;
                    model[p][CNTR_BUF_OVF]        = '0;
                end
            end
            // Sample control is zero here, so each mask bit is a 0-to-1 step
            sample_ports(32'(mask));
            bus_write({ADDR_ING_CNTRS_SAMPLE_CON, 2'b00}, 32'd0, 4'hF, RESP_OKAY);
            scan_counters();
            // A counter field past the bank must not reach into the next port
            read_counter(8'(r), 8'(NUM_CNTRS_PER_PORT), 32'd0);
        end
    endtask

    initial begin
        seed                    = 32'h036a_2556;
        peripheral_sresetn_core = 1'b0;
        address                 = '0;
        read                    = 1'b0;
        write                   = 1'b0;
        writedata               = '0;
        byteenable              = '0;
        ing_pkt_cnts            = '0;
        ing_byte_cnts           = '0;
        ing_err_cnts            = '0;
        ing_async_fifo_overflow = '0;
        ing_buf_overflow        = '0;
        for (int p = 0; p < NUM_PORTS; p++) begin
            for (int c = 0; c < NUM_CNTRS_PER_PORT; c++) model[p][c] = '0;
        end

        for (int i = 0; i < MAX_LINES; i++) patterns[i] = '1;
        $readmemh("testbench/router_regs_patterns.mem", patterns);
        num_lines = 0;
        while (num_lines < MAX_LINES && patterns[num_lines][95:88] != OP_NONE) num_lines++;
        cycle_limit = RESET_CYCLES + 20 * num_lines + 40 * RAND_ROUNDS * NUM_PORTS;
        if (num_lines == 0) begin
            $display("Error: pattern file is missing or empty");
            error_count++;
        end

        repeat (RESET_CYCLES) @(negedge avmm_clk_ifc);
        peripheral_sresetn_core = 1'b1;
        @(negedge avmm_clk_ifc);

        run_patterns();
        random_sampling();
        report_test(6);

        $display("Checks: %0d, errors: %0d", check_count, error_count);
        if (error_count == 0) begin
            $display("TESTS PASSED");
        end else begin
            $display("TESTS FAILED");
        end
        $finish;
    end

    // Cycle limit
    initial begin
        wait (cycle_limit > 0);
        while (cycle_count < cycle_limit) begin
            @(posedge avmm_clk_ifc);
            cycle_count++;
        end
        $display("Error: run stopped by timeout after %0d cycles", cycle_count);
        $display("TESTS FAILED");
        $finish;
    end

endmodule

`default_nettype wire

// File: testbench/router_regs_patterns.mem
// Columns: opcode_address_data_byteenable_expected, one hex word per line
// Ops 0 end test, 1 write, 2 read, 3 set count, 4 overflow edges, 5 sample, 6 wait,
// 7 counter window read (byteenable holds the counter, or the response for op 2)
// Reset and read-only values
02_0000_00000000_00_0100000A
02_0004_00000000_00_07D0200B
02_0008_00000000_00_000007FF
02_000C_00000000_00_000007FF
02_0010_00000000_00_00000000
02_0014_00000000_00_00000000
02_0018_00000000_00_00000000
00_0000_00000001_00_00000000
// Byte-lane writes and read-only registers
01_0008_00000555_01_00000000
02_0008_00000000_00_00000755
02_000C_00000000_00_00000755
01_0008_00000200_02_00000000
02_0008_00000000_00_00000255
02_000C_00000000_00_00000255
01_0014_FFFF0102_01_00000000
01_0014_00000500_02_00000000
02_0014_00000000_00_00000502
01_0000_FFFFFFFF_0F_00000000
02_0000_00000000_00_0100000A
01_000C_00000000_0F_00000000
02_000C_00000000_00_00000255
00_0000_00000002_00_00000000
// Addresses past the map
02_001C_00000000_02_00000000
02_7FFC_00000000_02_00000000
01_001C_FFFFFFFF_0F_00000002
01_7FFC_FFFFFFFF_0F_00000002
02_0000_00000000_00_0100000A
00_0000_00000003_00_00000000
// Sample port 3 only
03_0003_11110003_00_00000000
03_0003_22220003_01_00000000
03_0003_33330003_02_00000000
05_0000_00000008_00_00000000
01_0010_00000000_0F_00000000
07_0003_00000000_00_11110003
07_0003_00000000_01_22220003
07_0003_00000000_02_33330003
07_0002_00000000_00_00000000
00_0000_00000004_00_00000000
// Port p sees p+1 edges on both levels
04_FFFF_00000001_00_00000000
05_0000_000007FF_00_00000000
01_0010_00000000_0F_00000000
07_0000_00000000_03_00000001
07_0000_00000000_04_00000001
07_000A_00000000_03_0000000B
07_000A_00000000_04_0000000B
05_0000_000007FF_00_00000000
01_0010_00000000_0F_00000000
07_000A_00000000_03_00000000
07_000A_00000000_04_00000000
07_000B_00000000_00_00000000
07_0000_00000000_05_00000000
00_0000_00000005_00_00000000

// File: verilog.f
verilog/router_regs_pkg.sv
verilog/avmm_reg_decode.sv
verilog/ing_port_counters.sv
verilog/ing_cntr_read_mux.sv
verilog/router_avmm_regs.sv
testbench/router_avmm_regs_tb.sv

// File: Bender.yml
package:
  name: router_avmm_regs

sources:
  - files:
      - verilog/router_regs_pkg.sv
      - verilog/avmm_reg_decode.sv
      - verilog/ing_port_counters.sv
      - verilog/ing_cntr_read_mux.sv
      - verilog/router_avmm_regs.sv
  - target: test
    files:
      - testbench/router_avmm_regs_tb.sv
